// ==== otp_part_geom_pkg.sv ====
//////////////////////////////////////////////////
// OTP partition geometry
// Sizes, offsets and address widths of the buffered
// partition and of the macro's halfword address space
//////////////////////////////////////////////////

`default_nettype none

package otp_part_geom_pkg;

  // One buffered block, as returned by a single macro read
  localparam int unsigned BlockWidth = 64;

  // Whole partition in bytes, digest included
  localparam int unsigned PartSize = 32;

  // Last block of the partition holds the digest
  localparam int unsigned NumBlocks = PartSize / (BlockWidth / 8);
  localparam int unsigned BlkIdxWidth = $clog2(NumBlocks);

  // Byte offset of the partition inside the OTP array
  localparam int unsigned PartOffset = 64;

  // Macro address counts 16-bit halfwords
  localparam int unsigned OtpAddrWidth = 10;
  // Byte address to halfword address
  localparam int unsigned OtpAddrShift = 1;

  // Flat view of the buffer on the data output
  localparam int unsigned DataWidth = PartSize * 8;

endpackage

`default_nettype wire

// ==== otp_part_status_pkg.sv ====
//////////////////////////////////////////////////
// OTP partition status types
// Error codes seen on the macro and on the partition
// output, and the partition controller states
//////////////////////////////////////////////////

`default_nettype none

package otp_part_status_pkg;

  // Codes 4 and 5 are not used by this partition
  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroError          = 3'h1,
    MacroEccCorrError   = 3'h2,
    MacroEccUncorrError = 3'h3,
    CheckFailError      = 3'h6,
    FsmStateError       = 3'h7
  } otp_err_e;

  // Plain binary encoding, the three spare codes count as invalid
  typedef enum logic [2:0] {
    ResetSt = 3'h0,
    InitSt  = 3'h1,
    IdleSt  = 3'h2,
    CnstySt = 3'h3,
    ErrorSt = 3'h4
  } part_state_e;

endpackage

`default_nettype wire

// ==== otp_part_if.sv ====
//////////////////////////////////////////////////
// OTP partition internal channels
// Block read channel between controller and reader,
// buffer write channel between controller and buffer
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

// Block read channel
// Request and index stay up until the one-cycle done
interface part_rd_if;
  import otp_part_geom_pkg::*;
  import otp_part_status_pkg::*;

  logic                   rd_req;
  logic [BlkIdxWidth-1:0] rd_blk;
  logic                   rd_done;
  logic [BlockWidth-1:0]  rd_data;
  otp_err_e               rd_err;

  modport fsm (output rd_req, rd_blk, input rd_done, rd_data, rd_err);
  modport reader (input rd_req, rd_blk, output rd_done, rd_data, rd_err);
endinterface

// Buffer write channel
// wr_blk also selects the block returned for compare
interface buf_wr_if;
  import otp_part_geom_pkg::*;

  logic                   wr_en;
  logic [BlkIdxWidth-1:0] wr_blk;
  logic [BlockWidth-1:0]  wr_data;
  logic                   unlock;
  logic [BlockWidth-1:0]  rd_blk_data;
  logic                   par_err;

  modport fsm (output wr_en, wr_blk, wr_data, unlock, input rd_blk_data, par_err);
  modport buffer (input wr_en, wr_blk, wr_data, unlock, output rd_blk_data, par_err);
endinterface

`default_nettype wire

// ==== otp_part_reader.sv ====
//////////////////////////////////////////////////
// OTP partition block reader
// Turns one block request into a macro read, forms
// the halfword address and sorts the response code
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module otp_part_reader (
  input  wire                                        clk_i,
  input  wire                                        rst_ni,
  part_rd_if.reader                                  rd,
  output logic                                       otp_req_o,
  output logic [otp_part_geom_pkg::OtpAddrWidth-1:0] otp_addr_o,
  input  wire                                        otp_gnt_i,
  input  wire                                        otp_rvalid_i,
  input  wire  [otp_part_geom_pkg::BlockWidth-1:0]   otp_rdata_i,
  input  otp_part_status_pkg::otp_err_e              otp_err_i
);
  import otp_part_geom_pkg::*;
  import otp_part_status_pkg::*;

  logic                                 req_q;
  logic                                 wait_q;
  logic                                 done_q;
  logic                                 resp_fire;
  otp_err_e                             resp_err;
  otp_err_e                             err_q;
  logic [BlockWidth-1:0]                data_q;
  logic [OtpAddrWidth+OtpAddrShift-1:0] byte_addr;

  // Block base is the partition offset plus 8 bytes per index
  assign byte_addr = PartOffset[OtpAddrWidth+OtpAddrShift-1:0] +
                     {{(OtpAddrWidth + OtpAddrShift - BlkIdxWidth - $clog2(BlockWidth / 8)){1'b0}},
                      rd.rd_blk, {$clog2(BlockWidth / 8){1'b0}}};
  // Macro works on halfwords
  assign otp_addr_o = byte_addr[OtpAddrWidth+OtpAddrShift-1:OtpAddrShift];

  // Response may also arrive together with the grant
  assign resp_fire = otp_rvalid_i && (wait_q || (req_q && otp_gnt_i));

  // Codes the macro has no business sending count as macro errors
  always_comb begin
    case (otp_err_i)
      NoError:             resp_err = NoError;
      MacroEccCorrError:   resp_err = MacroEccCorrError;
      MacroEccUncorrError: resp_err = MacroEccUncorrError;
      default:             resp_err = MacroError;
    endcase
  end

  //////////////////////////////////////////////////
  // Request and response tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
      done_q <= 1'b0;
      err_q  <= NoError;
    end else begin
      done_q <= 1'b0;
      // Ignore the request still held during the done cycle
      if (!req_q && !wait_q && !done_q && rd.rd_req) begin
        req_q <= 1'b1;
      end
      if (req_q && otp_gnt_i) begin
        req_q  <= 1'b0;
        wait_q <= !otp_rvalid_i;
      end
      if (resp_fire) begin
        wait_q <= 1'b0;
        done_q <= 1'b1;
        err_q  <= resp_err;
      end
    end
  end

  // Read data register
  always_ff @(posedge clk_i) begin
    if (resp_fire) begin
      data_q <= otp_rdata_i;
    end
  end

  assign otp_req_o  = req_q;
  assign rd.rd_done = done_q;
  assign rd.rd_data = data_q;
  assign rd.rd_err  = err_q;

endmodule

`default_nettype wire

// ==== otp_part_fsm.sv ====
//////////////////////////////////////////////////
// OTP partition controller
// Sequences the init readout and the consistency
// check, latches error codes and owns the terminal
// error state
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module otp_part_fsm (
  input  wire                           clk_i,
  input  wire                           rst_ni,
  input  wire                           init_req_i,
  input  wire                           cnsty_chk_req_i,
  input  wire                           escalate_en_i,
  output logic                          init_done_o,
  output logic                          cnsty_chk_ack_o,
  output logic                          fsm_err_o,
  output otp_part_status_pkg::otp_err_e error_o,
  output logic                          in_error_o,
  part_rd_if.fsm                        rd,
  buf_wr_if.fsm                         wr
);
  import otp_part_geom_pkg::*;
  import otp_part_status_pkg::*;

  part_state_e            state_d, state_q;
  otp_err_e               error_d, error_q;
  logic [BlkIdxWidth-1:0] cnt_d, cnt_q;
  logic                   rd_req_d, rd_req_q;
  logic                   init_done_d, init_done_q;
  logic                   fsm_err_d, fsm_err_q;
  logic                   last_blk;
  logic                   rd_ok;
  logic                   invalid_st;

  assign last_blk = (cnt_q == BlkIdxWidth'(NumBlocks - 1));
  // Correctable ECC errors still deliver usable data
  assign rd_ok    = (rd.rd_err == NoError) || (rd.rd_err == MacroEccCorrError);

  // Block counter addresses both the read and the buffer
  assign rd.rd_req  = rd_req_q;
  assign rd.rd_blk  = cnt_q;
  assign wr.wr_blk  = cnt_q;
  assign wr.wr_data = rd.rd_data;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    error_d         = error_q;
    cnt_d           = cnt_q;
    rd_req_d        = rd_req_q;
    init_done_d     = init_done_q;
    wr.wr_en        = 1'b0;
    wr.unlock       = 1'b0;
    cnsty_chk_ack_o = 1'b0;
    invalid_st      = 1'b0;

    case (state_q)
      // Wait for the one init request
      ResetSt: begin
        if (init_req_i) begin
          state_d  = InitSt;
          cnt_d    = '0;
          rd_req_d = 1'b1;
        end
      end
      // Read blocks in order into the buffer
      InitSt: begin
        if (rd.rd_done) begin
          rd_req_d = 1'b0;
          if (rd_ok) begin
            wr.wr_en = 1'b1;
            if (rd.rd_err == MacroEccCorrError) begin
              error_d = MacroEccCorrError;
            end
            if (last_blk) begin
              state_d     = IdleSt;
              wr.unlock   = 1'b1;
              init_done_d = 1'b1;
            end else begin
              cnt_d = cnt_q + BlkIdxWidth'(1);
            end
          end else begin
            state_d = ErrorSt;
            error_d = rd.rd_err;
          end
        end else if (!rd_req_q) begin
          // Request gap after a done is over, next block
          rd_req_d = 1'b1;
        end
      end
      IdleSt: begin
        if (cnsty_chk_req_i) begin
          state_d  = CnstySt;
          cnt_d    = '0;
          rd_req_d = 1'b1;
        end
      end
      // Read back and compare against the buffered copy
      CnstySt: begin
        if (rd.rd_done) begin
          rd_req_d = 1'b0;
          if (!rd_ok) begin
            state_d         = ErrorSt;
            error_d         = rd.rd_err;
            cnsty_chk_ack_o = 1'b1;
          end else if (rd.rd_data != wr.rd_blk_data) begin
            state_d         = ErrorSt;
            error_d         = CheckFailError;
            cnsty_chk_ack_o = 1'b1;
          end else begin
            if (rd.rd_err == MacroEccCorrError) begin
              error_d = MacroEccCorrError;
            end
            if (last_blk) begin
              state_d         = IdleSt;
              cnsty_chk_ack_o = 1'b1;
            end else begin
              cnt_d = cnt_q + BlkIdxWidth'(1);
            end
          end
        end else if (!rd_req_q) begin
          rd_req_d = 1'b1;
        end
      end
      // Terminal, checks can no longer run so acks come at once
      ErrorSt: begin
        cnsty_chk_ack_o = cnsty_chk_req_i;
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
      default: begin
        invalid_st = 1'b1;
      end
    endcase

    // Buffer parity, escalation and glitched states end here
    if (wr.par_err || escalate_en_i || invalid_st) begin
      state_d = ErrorSt;
      if (error_d == NoError) begin
        error_d = FsmStateError;
      end
    end
    if (state_d == ErrorSt) begin
      rd_req_d    = 1'b0;
      init_done_d = 1'b0;
    end
    fsm_err_d = (escalate_en_i || invalid_st) && (state_q != ErrorSt);
  end

  //////////////////////////////////////////////////
  // State registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ResetSt;
      error_q     <= NoError;
      cnt_q       <= '0;
      rd_req_q    <= 1'b0;
      init_done_q <= 1'b0;
      fsm_err_q   <= 1'b0;
    end else begin
      state_q     <= state_d;
      error_q     <= error_d;
      cnt_q       <= cnt_d;
      rd_req_q    <= rd_req_d;
      init_done_q <= init_done_d;
      fsm_err_q   <= fsm_err_d;
    end
  end

  assign error_o     = error_q;
  assign init_done_o = init_done_q;
  assign fsm_err_o   = fsm_err_q;
  assign in_error_o  = (state_q == ErrorSt);

endmodule

`default_nettype wire

// ==== otp_part_buffer.sv ====
//////////////////////////////////////////////////
// OTP partition buffer
// Parity-protected block registers, gated data
// output and software access locks
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module otp_part_buffer (
  input  wire                                     clk_i,
  input  wire                                     rst_ni,
  buf_wr_if.buffer                                wr,
  input  wire                                     in_error_i,
  input  wire                                     write_lock_i,
  input  wire                                     read_lock_i,
  output logic                                    write_lock_o,
  output logic                                    read_lock_o,
  output logic [otp_part_geom_pkg::DataWidth-1:0] data_o,
  output logic [otp_part_geom_pkg::BlockWidth-1:0] digest_o
);
  import otp_part_geom_pkg::*;

  logic [BlockWidth-1:0] blk_q [NumBlocks];
  logic [NumBlocks-1:0]  par_q;
  logic [NumBlocks-1:0]  filled_q;
  logic [NumBlocks-1:0]  par_bad;
  logic [DataWidth-1:0]  data_flat;
  logic                  unlocked_q;
  logic                  write_lock_q;
  logic                  read_lock_q;

  // Block storage, even parity bit per block
  always_ff @(posedge clk_i) begin
    if (wr.wr_en) begin
      blk_q[wr.wr_blk] <= wr.wr_data;
      par_q[wr.wr_blk] <= ^wr.wr_data;
    end
  end

  // Only blocks written since reset take part in the check
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      filled_q <= '0;
    end else if (wr.wr_en) begin
      filled_q[wr.wr_blk] <= 1'b1;
    end
  end

  // Parity check and flat output view, block 0 in the low bits
  always_comb begin
    for (int i = 0; i < NumBlocks; i++) begin
      par_bad[i] = filled_q[i] && (^{blk_q[i], par_q[i]});
      data_flat[i*BlockWidth +: BlockWidth] = blk_q[i];
    end
  end

  assign wr.par_err     = |par_bad;
  assign wr.rd_blk_data = blk_q[wr.wr_blk];

  //////////////////////////////////////////////////
  // Output gating and locks
  //////////////////////////////////////////////////

  // Error wins over unlock, and the error state never ends
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unlocked_q   <= 1'b0;
      write_lock_q <= 1'b1;
      read_lock_q  <= 1'b1;
    end else begin
      if (in_error_i) begin
        unlocked_q <= 1'b0;
      end else if (wr.unlock) begin
        unlocked_q <= 1'b1;
      end
      // A programmed digest freezes the partition for writes
      write_lock_q <= write_lock_i || !unlocked_q || (blk_q[NumBlocks-1] != '0);
      read_lock_q  <= read_lock_i || !unlocked_q;
    end
  end

  assign data_o       = unlocked_q ? data_flat : '0;
  // Digest is not gated
  assign digest_o     = blk_q[NumBlocks-1];
  assign write_lock_o = write_lock_q;
  assign read_lock_o  = read_lock_q;

endmodule

`default_nettype wire

// ==== otp_part_buf_top.sv ====
//////////////////////////////////////////////////
// Buffered OTP partition
// Reader, controller and buffer joined over the two
// internal channels
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module otp_part_buf_top (
  input  wire                                        clk_i,
  input  wire                                        rst_ni,
  // Init and check handshakes
  input  wire                                        init_req_i,
  output logic                                       init_done_o,
  input  wire                                        cnsty_chk_req_i,
  output logic                                       cnsty_chk_ack_o,
  input  wire                                        escalate_en_i,
  output otp_part_status_pkg::otp_err_e              error_o,
  output logic                                       fsm_err_o,
  // Software access locks
  input  wire                                        write_lock_i,
  input  wire                                        read_lock_i,
  output logic                                       write_lock_o,
  output logic                                       read_lock_o,
  // Buffered contents
  output logic [otp_part_geom_pkg::DataWidth-1:0]    data_o,
  output logic [otp_part_geom_pkg::BlockWidth-1:0]   digest_o,
  // OTP macro
  output logic                                       otp_req_o,
  output logic [otp_part_geom_pkg::OtpAddrWidth-1:0] otp_addr_o,
  input  wire                                        otp_gnt_i,
  input  wire                                        otp_rvalid_i,
  input  wire  [otp_part_geom_pkg::BlockWidth-1:0]   otp_rdata_i,
  input  otp_part_status_pkg::otp_err_e              otp_err_i
);

  logic in_error;

  part_rd_if u_rd_if ();
  buf_wr_if  u_wr_if ();

  otp_part_reader u_reader (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd           (u_rd_if),
    .otp_req_o    (otp_req_o),
    .otp_addr_o   (otp_addr_o),
    .otp_gnt_i    (otp_gnt_i),
    .otp_rvalid_i (otp_rvalid_i),
    .otp_rdata_i  (otp_rdata_i),
    .otp_err_i    (otp_err_i)
  );

  otp_part_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .init_req_i      (init_req_i),
    .cnsty_chk_req_i (cnsty_chk_req_i),
    .escalate_en_i   (escalate_en_i),
    .init_done_o     (init_done_o),
    .cnsty_chk_ack_o (cnsty_chk_ack_o),
    .fsm_err_o       (fsm_err_o),
    .error_o         (error_o),
    .in_error_o      (in_error),
    .rd              (u_rd_if),
    .wr              (u_wr_if)
  );

  otp_part_buffer u_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr           (u_wr_if),
    .in_error_i   (in_error),
    .write_lock_i (write_lock_i),
    .read_lock_i  (read_lock_i),
    .write_lock_o (write_lock_o),
    .read_lock_o  (read_lock_o),
    .data_o       (data_o),
    .digest_o     (digest_o)
  );

endmodule

`default_nettype wire

// ==== otp_part_checker.sv ====
//////////////////////////////////////////////////
// OTP partition checker
// Watches the buffered partition, keeps its own
// model of state and error code and compares
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module otp_part_checker (
  input  wire                                      clk_i,
  input  wire                                      rst_ni,
  input  wire  [otp_part_geom_pkg::DataWidth-1:0]  image_i,
  input  wire                                      init_req_i,
  input  wire                                      cnsty_chk_req_i,
  input  wire                                      escalate_en_i,
  input  wire                                      wl_in_i,
  input  wire                                      rl_in_i,
  input  wire                                      otp_req_i,
  input  wire                                      otp_gnt_i,
  input  wire  [otp_part_geom_pkg::OtpAddrWidth-1:0] otp_addr_i,
  input  wire                                      otp_rvalid_i,
  input  otp_part_status_pkg::otp_err_e            otp_err_i,
  input  wire                                      init_done_i,
  input  wire                                      ack_i,
  input  wire                                      fsm_err_i,
  input  otp_part_status_pkg::otp_err_e            error_i,
  input  wire                                      wl_out_i,
  input  wire                                      rl_out_i,
  input  wire  [otp_part_geom_pkg::DataWidth-1:0]  data_i,
  input  wire  [otp_part_geom_pkg::BlockWidth-1:0] digest_i,
  output int                                       err_cnt_o,
  output int                                       chk_cnt_o
);
  import otp_part_geom_pkg::*;
  import otp_part_status_pkg::*;

  part_state_e            st;
  otp_err_e               exp_err;
  logic [DataWidth-1:0]   snap;
  logic [BlkIdxWidth-1:0] blk_cnt;
  logic                   chk_fail;
  logic                   done_seen;
  logic                   fsm_exp;
  logic                   gnt_d1;
  logic                   wl_d1, wl_d2, rl_d1, rl_d2;
  int                     err_age;
  int                     err_cnt = 0;
  int                     chk_cnt = 0;

  // Expected locks as {write lock, read lock}
  function automatic logic [1:0] expected_locks(input logic wl, input logic rl, input logic unl,
                                                input logic [BlockWidth-1:0] dig);
    expected_locks = {wl || !unl || (dig != '0), rl || !unl};
  endfunction

  // Halfword address of a block from the partition offset and 8 bytes per block
  function automatic logic [OtpAddrWidth-1:0] block_addr(input int blk);
    block_addr = OtpAddrWidth'((PartOffset + blk * (BlockWidth / 8)) >> OtpAddrShift);
  endfunction

  task automatic compare(input logic ok, input string what);
    chk_cnt++;
    if (!ok) begin
      err_cnt++;
      $display("FAIL at %0t: %s", $time, what);
    end
  endtask

  //////////////////////////////////////////////////
  // Compare this cycle, then advance the model
  //////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st        <= ResetSt;
      exp_err   <= NoError;
      snap      <= '0;
      blk_cnt   <= '0;
      chk_fail  <= 1'b0;
      done_seen <= 1'b0;
      fsm_exp   <= 1'b0;
      gnt_d1    <= 1'b0;
      err_age   <= 0;
      {wl_d1, wl_d2, rl_d1, rl_d2} <= '0;
    end else begin
      compare(fsm_err_i == fsm_exp, "fsm_err_o pulse differs from escalation");
      if (exp_err == NoError) begin
        compare(error_i == NoError, "error_o raised without a cause");
      end
      if (!done_seen && !init_done_i) begin
        compare(data_i == '0, "data_o not zero before init done");
      end
      if (st != CnstySt && st != ErrorSt) begin
        compare(!ack_i, "check ack outside a check");
      end
      // Macro sees the blocks in order and the request drops once granted
      if (otp_req_i && otp_gnt_i) begin
        compare(otp_addr_i == block_addr(int'(blk_cnt)), "otp_addr_o not the next block");
      end
      if (gnt_d1) begin
        compare(!otp_req_i, "otp_req_o still high after the grant");
      end
      // First cycle of init done
      if (init_done_i && !done_seen) begin
        compare(st == IdleSt, "init_done_o without a full readout");
        compare(data_i == snap, "data_o differs from memory image");
        compare(digest_i == snap[DataWidth-1 -: BlockWidth], "digest_o differs from block 3");
        compare(error_i == exp_err, "error_o wrong at init done");
      end
      // Lock inputs moved one cycle ago
      if (wl_d1 != wl_d2 || rl_d1 != rl_d2) begin
        compare({wl_out_i, rl_out_i} ==
                expected_locks(wl_d1, rl_d1, st == IdleSt || st == CnstySt,
                               snap[DataWidth-1 -: BlockWidth]),
                "lock outputs break the lock rule");
      end
      // Settled terminal state
      if (st == ErrorSt && err_age >= 4) begin
        compare(error_i == exp_err, "error_o wrong in error state");
        compare(data_i == '0, "data_o not zero in error state");
        compare(wl_out_i && rl_out_i, "locks not both high in error state");
        compare(!init_done_i, "init_done_o high in error state");
        compare(ack_i == cnsty_chk_req_i, "check ack does not follow request in error state");
      end

      done_seen <= done_seen || init_done_i;
      fsm_exp   <= escalate_en_i && (st != ErrorSt);
      gnt_d1    <= otp_req_i && otp_gnt_i;
      wl_d1     <= wl_in_i;
      wl_d2     <= wl_d1;
      rl_d1     <= rl_in_i;
      rl_d2     <= rl_d1;
      if (st == ErrorSt && err_age < 4) begin
        err_age <= err_age + 1;
      end

      case (st)
        ResetSt: begin
          if (init_req_i) begin
            st      <= InitSt;
            snap    <= image_i;
            blk_cnt <= '0;
          end
        end
        InitSt: begin
          if (otp_rvalid_i) begin
            if (otp_err_i == NoError || otp_err_i == MacroEccCorrError) begin
              if (otp_err_i == MacroEccCorrError) begin
                exp_err <= MacroEccCorrError;
              end
              if (blk_cnt == BlkIdxWidth'(NumBlocks - 1)) begin
                st <= IdleSt;
              end
              blk_cnt <= blk_cnt + BlkIdxWidth'(1);
            end else begin
              st      <= ErrorSt;
              exp_err <= otp_err_i;
              err_age <= 1;
            end
          end
        end
        IdleSt: begin
          if (cnsty_chk_req_i) begin
            st       <= CnstySt;
            blk_cnt  <= '0;
            chk_fail <= (image_i != snap);
          end
        end
        CnstySt: begin
          if (otp_rvalid_i) begin
            blk_cnt <= blk_cnt + BlkIdxWidth'(1);
          end
          if (ack_i && chk_fail) begin
            st      <= ErrorSt;
            exp_err <= CheckFailError;
            err_age <= 1;
          end else if (ack_i) begin
            compare(error_i == exp_err, "error_o wrong after a passing check");
            st <= IdleSt;
          end
        end
        default: begin
        end
      endcase

      // Escalation wins over everything else
      if (escalate_en_i && st != ErrorSt) begin
        st      <= ErrorSt;
        err_age <= 1;
        if (exp_err == NoError) begin
          exp_err <= FsmStateError;
        end
      end
    end
  end

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

endmodule

`default_nettype wire

// ==== tb_otp_part_buf.sv ====
//////////////////////////////////////////////////
// Buffered OTP partition testbench
// Clock, reset, OTP macro model, test sequence
// and watchdog around the partition
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_otp_part_buf;
  import otp_part_geom_pkg::*;
  import otp_part_status_pkg::*;

  localparam int NumTests      = 5;
  localparam int CyclesPerTest = 400;
  localparam int HsTimeout     = 300;

  logic                    clk_i, rst_ni;
  logic                    init_req_i, init_done_o;
  logic                    cnsty_chk_req_i, cnsty_chk_ack_o;
  logic                    escalate_en_i, fsm_err_o;
  otp_err_e                error_o;
  logic                    write_lock_i, read_lock_i, write_lock_o, read_lock_o;
  logic [DataWidth-1:0]    data_o;
  logic [BlockWidth-1:0]   digest_o;
  logic                    otp_req_o, otp_gnt_i, otp_rvalid_i;
  logic [OtpAddrWidth-1:0] otp_addr_o;
  logic [BlockWidth-1:0]   otp_rdata_i;
  otp_err_e                otp_err_i;

  // Memory image with block 0 in the low bits
  logic [DataWidth-1:0]    image;
  int                      rd_cnt = 0;
  int                      inj_read = -1;
  otp_err_e                inj_code = NoError;
  int                      tb_errs = 0;
  int                      chk_errs, chk_total;

  otp_part_buf_top uut (.*);

  otp_part_checker u_checker (
    .clk_i, .rst_ni, .image_i (image), .init_req_i, .cnsty_chk_req_i, .escalate_en_i,
    .wl_in_i (write_lock_i), .rl_in_i (read_lock_i),
    .otp_req_i (otp_req_o), .otp_gnt_i, .otp_addr_i (otp_addr_o), .otp_rvalid_i, .otp_err_i,
    .init_done_i (init_done_o), .ack_i (cnsty_chk_ack_o), .fsm_err_i (fsm_err_o),
    .error_i (error_o), .wl_out_i (write_lock_o), .rl_out_i (read_lock_o),
    .data_i (data_o), .digest_i (digest_o), .err_cnt_o (chk_errs), .chk_cnt_o (chk_total)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Halfword address back to block index
  function automatic int block_of_addr(input logic [OtpAddrWidth-1:0] a);
    block_of_addr = ((int'(a) << OtpAddrShift) - int'(PartOffset)) / (BlockWidth / 8);
  endfunction

  //////////////////////////////////////////////////
  // OTP macro model
  //////////////////////////////////////////////////

  initial begin : otp_model
    int gnt_dly;
    int rv_dly;
    int blk;
    otp_gnt_i    = 1'b0;
    otp_rvalid_i = 1'b0;
    otp_rdata_i  = '0;
    otp_err_i    = NoError;
    forever begin
      @(negedge clk_i);
      otp_gnt_i    = 1'b0;
      otp_rvalid_i = 1'b0;
      otp_err_i    = NoError;
      if (otp_req_o) begin
        gnt_dly = $urandom % 6;
        repeat (gnt_dly) @(negedge clk_i);
        blk       = block_of_addr(otp_addr_o);
        otp_gnt_i = 1'b1;
        rv_dly    = $urandom % 6;
        // Zero delay puts the response on the grant cycle
        if (rv_dly > 0) begin
          @(negedge clk_i);
          otp_gnt_i = 1'b0;
          repeat (rv_dly - 1) @(negedge clk_i);
        end
        otp_rvalid_i = 1'b1;
        otp_rdata_i  = image[blk*BlockWidth +: BlockWidth];
        otp_err_i    = (rd_cnt == inj_read) ? inj_code : NoError;
        rd_cnt++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Sequence tasks
  //////////////////////////////////////////////////

  task automatic fill_image(input logic blank_digest);
    for (int i = 0; i < NumBlocks; i++) begin
      image[i*BlockWidth +: BlockWidth] = {$urandom(), $urandom()} ^ {8{8'(i + 90)}};
    end
    image[DataWidth-1 -: BlockWidth] = blank_digest ? '0 : {$urandom(), $urandom() | 32'h1};
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni          = 1'b0;
    init_req_i      = 1'b0;
    cnsty_chk_req_i = 1'b0;
    escalate_en_i   = 1'b0;
    write_lock_i    = 1'b0;
    read_lock_i     = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic request_init();
    @(negedge clk_i);
    init_req_i = 1'b1;
    @(negedge clk_i);
    init_req_i = 1'b0;
  endtask

  task automatic wait_init_done();
    int n;
    n = 0;
    while (!init_done_o && n < HsTimeout) begin
      @(posedge clk_i);
      n++;
    end
    if (!init_done_o) begin
      tb_errs++;
      $display("Init readout did not finish within %0d cycles", HsTimeout);
    end
  endtask

  task automatic run_check();
    int n;
    n = 0;
    @(negedge clk_i);
    cnsty_chk_req_i = 1'b1;
    do begin
      @(posedge clk_i);
      n++;
    end while (!cnsty_chk_ack_o && n < HsTimeout);
    if (!cnsty_chk_ack_o) begin
      tb_errs++;
      $display("Consistency check was not acknowledged within %0d cycles", HsTimeout);
    end
    @(negedge clk_i);
    cnsty_chk_req_i = 1'b0;
  endtask

  // One input change every two cycles
  task automatic toggle_locks();
    @(negedge clk_i) write_lock_i = 1'b1;
    repeat (2) @(negedge clk_i);
    read_lock_i = 1'b1;
    repeat (2) @(negedge clk_i);
    write_lock_i = 1'b0;
    repeat (2) @(negedge clk_i);
    read_lock_i = 1'b0;
    repeat (2) @(negedge clk_i);
  endtask

  initial begin : stimulus
    void'($urandom(32'hd33f8f00));
    rst_ni          = 1'b0;
    init_req_i      = 1'b0;
    cnsty_chk_req_i = 1'b0;
    escalate_en_i   = 1'b0;
    write_lock_i    = 1'b0;
    read_lock_i     = 1'b0;
    // Clean readout, blank digest, then locks
    fill_image(1'b1);
    apply_reset();
    request_init();
    wait_init_done();
    toggle_locks();
    // Passing check, then one block changed underneath
    run_check();
    image[BlockWidth +: BlockWidth] = ~image[BlockWidth +: BlockWidth];
    run_check();
    repeat (8) @(negedge clk_i);
    toggle_locks();
    // Correctable ECC on block 2, programmed digest
    fill_image(1'b0);
    inj_read = rd_cnt + 2;
    inj_code = MacroEccCorrError;
    apply_reset();
    request_init();
    wait_init_done();
    toggle_locks();
    // Uncorrectable ECC on block 1
    inj_read = rd_cnt + 1;
    inj_code = MacroEccUncorrError;
    apply_reset();
    request_init();
    repeat (60) @(negedge clk_i);
    // Escalation in idle, then a check in the error state
    inj_read = -1;
    apply_reset();
    request_init();
    wait_init_done();
    @(negedge clk_i) escalate_en_i = 1'b1;
    @(negedge clk_i) escalate_en_i = 1'b0;
    repeat (8) @(negedge clk_i);
    run_check();
    repeat (4) @(negedge clk_i);

    $display("Errors: checker %0d, sequence %0d, over %0d checks", chk_errs, tb_errs, chk_total);
    if (chk_errs == 0 && tb_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (NumTests * CyclesPerTest) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, run did not finish", NumTests * CyclesPerTest);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
otp_part_geom_pkg.sv
otp_part_status_pkg.sv
otp_part_if.sv
otp_part_reader.sv
otp_part_fsm.sv
otp_part_buffer.sv
otp_part_buf_top.sv
otp_part_checker.sv
tb_otp_part_buf.sv

// ==== Makefile ====
# Verilator build and run of the buffered OTP partition testbench

VERILATOR ?= verilator
TOP       ?= tb_otp_part_buf
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
